//--- project.f
hw/fetchPkg.sv
hw/fetchControl.sv
hw/pcDatapath.sv
hw/instrMemory.sv
hw/misalignCheck.sv
hw/fetchUnit.sv
bench/fetchUnit_assert.sv
bench/fetchUnitTb.sv

//--- bench/fetchUnitTb.sv
// fetch front end testbench: directed tests checked against a model of the pc rules
`timescale 1ns/1ps

module fetchUnitTb;

  import fetchPkg::*;

  logic          clk;
  logic          reset;
  logic          stallF;
  branchResolveT branch;
  privRedirectT  priv;
  imemLoadT      load;
  fetchOutT      fetch;
  misalignFaultT fault;

  // halfword image of the instruction store
  logic [15:0]     hwModel [0:IMEM_HALFWORDS-1];
  logic [31:0]     lfsrState;
  // model pc, and the fault due after the next edge
  logic [XLEN-1:0] expPc;
  misalignFaultT   expFault;

  fetchUnit DUT (
    .clk    (clk),
    .reset  (reset),
    .stallF (stallF),
    .branch (branch),
    .priv   (priv),
    .load   (load),
    .fetch  (fetch),
    .fault  (fault)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus helpers and reference model
  //////////////////////////////////////////////////////////////////////

  // galois form, taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  // one lfsr step per bit taken
  task automatic takeBits(input int n, output logic [15:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits = {bits[14:0], lfsrState[0]};
      lfsrState = lfsrNext(lfsrState);
    end
  endtask

  function automatic branchResolveT makeBranch(input logic taken, input logic [31:0] imm,
                                               input logic [31:0] base);
    return '{taken: taken, imm: imm, base: base};
  endfunction

  function automatic privRedirectT makePriv(input logic ret, input logic trap,
                                            input logic [31:0] nextPc);
    return '{ret: ret, trap: trap, nextPc: nextPc};
  endfunction

  // halfword at pc in the low bits, the following one above, wrapping
  function automatic logic [31:0] modelInstr(input logic [XLEN-1:0] pc);
    int idx;
    idx = (pc >> 1) % IMEM_HALFWORDS;
    return {hwModel[(idx + 1) % IMEM_HALFWORDS], hwModel[idx]};
  endfunction

  // 16-bit parcels end in anything but 11
  function automatic logic [XLEN-1:0] modelPcPlus(input logic [XLEN-1:0] pc,
                                                  input logic [31:0] instr);
    if (instr[1:0] != 2'b11) begin
      return pc + 32'd2;
    end
    return pc + 32'd4;
  endfunction

  function automatic fetchOutT expectedFetch(input logic [XLEN-1:0] pc);
    logic [31:0] instr;
    instr = modelInstr(pc);
    return '{pc: pc, instr: instr, pcPlus: modelPcPlus(pc, instr)};
  endfunction

  // random parcels, one lfsr bit decides full width
  task automatic fillModel();
    logic [15:0] upper;
    logic [15:0] wide;
    logic [15:0] low;
    for (int i = 0; i < IMEM_HALFWORDS; i++) begin
      takeBits(14, upper);
      takeBits(1, wide);
      takeBits(2, low);
      if (wide[0]) begin
        low[1:0] = 2'b11;
      end else if (low[1:0] == 2'b11) begin
        low[1:0] = 2'b01;
      end
      hwModel[i] = {upper[13:0], low[1:0]};
    end
  endtask

  task automatic applyReset();
    reset <= 1'b1;
    repeat (16) @(posedge clk);
    reset <= 1'b0;
  endtask

  // one halfword per cycle, overlapping reset
  task automatic loadMemory();
    for (int i = 0; i < IMEM_HALFWORDS; i++) begin
      @(posedge clk);
      load <= '{we: 1'b1, addr: i[IMEM_AW-1:0], data: hwModel[i]};
    end
    @(posedge clk);
    load <= '0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic abortRun();
    $display("Simulation failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic checkFetch(input string name, input fetchOutT exp, input fetchOutT act);
    if (act !== exp) begin
      $display("error %s: expected pc=%h instr=%h pcPlus=%h, actual pc=%h instr=%h pcPlus=%h",
               name, exp.pc, exp.instr, exp.pcPlus, act.pc, act.instr, act.pcPlus);
      abortRun();
    end
  endtask

  // address only matters together with the flag
  task automatic checkFault(input string name, input misalignFaultT exp,
                            input misalignFaultT act);
    if (act.fault !== exp.fault || (exp.fault && act.adr !== exp.adr)) begin
      $display("error %s: expected fault=%b adr=%h, actual fault=%b adr=%h",
               name, exp.fault, exp.adr, act.fault, act.adr);
      abortRun();
    end
  endtask

  // drive one cycle, check the current outputs, then advance the model
  task automatic runCycle(input string name, input logic stallV, input branchResolveT br,
                          input privRedirectT pv);
    fetchOutT        expF;
    logic [XLEN-1:0] target;
    logic [XLEN-1:0] unaligned;
    logic            privOn;
    @(posedge clk);
    stallF <= stallV;
    branch <= br;
    priv   <= pv;
    @(negedge clk);
    expF = expectedFetch(expPc);
    checkFetch(name, expF, fetch);
    checkFault(name, expFault, fault);
    // priority: privileged, branch, sequential
    privOn = pv.ret | pv.trap;
    target = br.imm + br.base;
    if (privOn) begin
      unaligned = pv.nextPc;
    end else if (br.taken) begin
      unaligned = target;
    end else begin
      unaligned = expF.pcPlus;
    end
    // any redirect overrides the stall
    if (!stallV || privOn || br.taken) begin
      expPc = {unaligned[XLEN-1:1], 1'b0};
    end
    expFault.fault = br.taken & ~privOn & target[0];
    expFault.adr   = unaligned;
  endtask

  task automatic waitForFault(input string name, input int limit);
    int   n;
    logic seen;
    n = 0;
    seen = 1'b0;
    while (!seen && n < limit) begin
      runCycle(name, 1'b0, makeBranch(1'b0, 0, 0), makePriv(1'b0, 1'b0, 0));
      n++;
      seen = (fault.fault === 1'b1);
    end
    if (!seen) begin
      $display("timeout: no misaligned fault within %0d cycles in %s", limit, name);
      abortRun();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////////////////////////

  // stall is still high, so the pc sits at the reset vector
  task automatic testReset();
    @(negedge clk);
    checkFetch("reset", expectedFetch(PC_START), fetch);
    checkFault("reset", '0, fault);
    expPc    = PC_START;
    expFault = '0;
  endtask

  task automatic testSequential();
    repeat (40) runCycle("sequential", 1'b0, makeBranch(1'b0, 0, 0), makePriv(1'b0, 1'b0, 0));
  endtask

  task automatic testStall();
    repeat (4) runCycle("stall hold", 1'b1, makeBranch(1'b0, 0, 0), makePriv(1'b0, 1'b0, 0));
    runCycle("stall with branch", 1'b1, makeBranch(1'b1, 32'h20, 32'h40),
             makePriv(1'b0, 1'b0, 0));
    repeat (3) runCycle("stall after branch", 1'b1, makeBranch(1'b0, 0, 0),
                        makePriv(1'b0, 1'b0, 0));
    repeat (3) runCycle("stall release", 1'b0, makeBranch(1'b0, 0, 0), makePriv(1'b0, 1'b0, 0));
  endtask

  task automatic testBranch();
    // negative offset
    runCycle("aligned branch", 1'b0, makeBranch(1'b1, 32'hFFFF_FFFA, 32'hC4),
             makePriv(1'b0, 1'b0, 0));
    repeat (2) runCycle("after branch", 1'b0, makeBranch(1'b0, 0, 0), makePriv(1'b0, 1'b0, 0));
    // target above the store wraps in the memory read
    runCycle("far branch", 1'b0, makeBranch(1'b1, 32'h1000_0000, 32'h2),
             makePriv(1'b0, 1'b0, 0));
    runCycle("misaligned branch", 1'b0, makeBranch(1'b1, 32'h11, 32'h90),
             makePriv(1'b0, 1'b0, 0));
    waitForFault("misaligned branch", 8);
    repeat (2) runCycle("fault clears", 1'b0, makeBranch(1'b0, 0, 0), makePriv(1'b0, 1'b0, 0));
  endtask

  task automatic testPriv();
    runCycle("ret over branch", 1'b0, makeBranch(1'b1, 32'h11, 32'h90),
             makePriv(1'b1, 1'b0, 32'hD3));
    repeat (2) runCycle("after ret", 1'b0, makeBranch(1'b0, 0, 0), makePriv(1'b0, 1'b0, 0));
    runCycle("trap over stall and branch", 1'b1, makeBranch(1'b1, 32'h5, 32'h40),
             makePriv(1'b0, 1'b1, 32'h84));
    repeat (2) runCycle("after trap", 1'b0, makeBranch(1'b0, 0, 0), makePriv(1'b0, 1'b0, 0));
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    reset     = 1'b1;
    stallF    = 1'b1;
    branch    = '0;
    priv      = '0;
    load      = '0;
    lfsrState = 32'hea2;
    expPc     = PC_START;
    expFault  = '0;
    fillModel();
    // pc stays at the reset vector while the load finishes under stall
    fork
      applyReset();
      loadMemory();
    join
    testReset();
    testSequential();
    testStall();
    testBranch();
    testPriv();
    if (DUT.assertChecks.failCount == 0) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      $display("%0d assertion failures", DUT.assertChecks.failCount);
      abortRun();
    end
  end

endmodule

//--- bench/fetchUnit_assert.sv
// fetch front end assertions: pc alignment, fault timing and reset vector
`timescale 1ns/1ps

module fetchUnitAssert (
  input logic                    clk,
  input logic                    reset,
  input fetchPkg::branchResolveT branch,
  input fetchPkg::fetchOutT      fetch,
  input fetchPkg::misalignFaultT fault
);

  import fetchPkg::*;

  // raw execute-stage target
  logic [XLEN-1:0] target;
  // taken branch whose target has bit 0 set
  logic            oddTaken;
  // number of failed properties
  int              failCount = 0;

  assign target   = branch.imm + branch.base;
  assign oddTaken = branch.taken & target[0];

  // fetch never runs from an odd address
  pcAligned: assert property (@(posedge clk) disable iff (reset) !fetch.pc[0])
    else begin
      failCount++;
      $error("fetch pc %h has bit 0 set", fetch.pc);
    end

  // fault only one cycle after an odd taken branch, with its raw target
  faultTiming: assert property (@(posedge clk) disable iff (reset)
    fault.fault |-> ($past(oddTaken) && fault.adr == $past(target)))
    else begin
      failCount++;
      $error("fault %h raised without an odd taken branch before it", fault.adr);
    end

  // reset vector is in place right after every reset cycle
  resetVector: assert property (@(posedge clk) reset |=> fetch.pc == PC_START)
    else begin
      failCount++;
      $error("fetch pc %h after reset", fetch.pc);
    end

endmodule

bind fetchUnit fetchUnitAssert assertChecks (
  .clk    (clk),
  .reset  (reset),
  .branch (branch),
  .fetch  (fetch),
  .fault  (fault)
);

//--- hw/fetchUnit.sv
// instruction fetch front end: pc control, pc datapath, instruction store and misaligned check
`timescale 1ns/1ps

module fetchUnit (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    stallF,
  input  fetchPkg::branchResolveT branch,
  input  fetchPkg::privRedirectT  priv,
  input  fetchPkg::imemLoadT      load,
  output fetchPkg::fetchOutT      fetch,
  output fetchPkg::misalignFaultT fault
);

  import fetchPkg::*;

  // control to datapath
  pcSrcT           pcSel;
  logic            pcEn;

  // fetch stage values
  logic [XLEN-1:0] pcF;
  logic [31:0]     instrF;
  logic [XLEN-1:0] pcPlusF;

  // next pc before bit 0 is cleared
  logic [XLEN-1:0] unalignedNext;

  //////////////////////////////////////////////////////////////////////
  // control and datapath
  //////////////////////////////////////////////////////////////////////

  fetchControl control (
    .clk         (clk),
    .reset       (reset),
    .stallF      (stallF),
    .branchTaken (branch.taken),
    .privRet     (priv.ret),
    .privTrap    (priv.trap),
    .pcSel       (pcSel),
    .pcEn        (pcEn)
  );

  pcDatapath datapath (
    .clk           (clk),
    .reset         (reset),
    .pcSel         (pcSel),
    .pcEn          (pcEn),
    .branch        (branch),
    .privNextPc    (priv.nextPc),
    .instrF        (instrF),
    .pcF           (pcF),
    .pcPlusF       (pcPlusF),
    .unalignedNext (unalignedNext)
  );

  // instruction store, read at the current pc
  instrMemory imem (
    .clk   (clk),
    .load  (load),
    .pc    (pcF),
    .instr (instrF)
  );

  // branch target alignment fault
  misalignCheck misalign (
    .clk           (clk),
    .reset         (reset),
    .pcSel         (pcSel),
    .unalignedNext (unalignedNext),
    .fault         (fault)
  );

  // bundle for decode
  assign fetch = '{pc: pcF, instr: instrF, pcPlus: pcPlusF};

endmodule

//--- hw/misalignCheck.sv
// misaligned branch target check, fault and address registered into the memory stage
`timescale 1ns/1ps

module misalignCheck (
  input  logic                      clk,
  input  logic                      reset,
  input  fetchPkg::pcSrcT           pcSel,
  input  logic [fetchPkg::XLEN-1:0] unalignedNext,
  output fetchPkg::misalignFaultT   fault
);

  import fetchPkg::*;

  // target is not halfword aligned
  logic misaligned;
  // execute-stage branch fault
  logic branchFaultE;

  //////////////////////////////////////////////////////////////////////
  // detection
  //////////////////////////////////////////////////////////////////////

  // compressed support allows halfword targets, only bit 0 is illegal
  assign misaligned = unalignedNext[0];

  // only a branch or jump that actually steers the pc can fault
  // privileged redirects are not checked here, the trap path is off
  assign branchFaultE = misaligned & (pcSel == pcBranch);

  //////////////////////////////////////////////////////////////////////
  // execute to memory stage register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      fault <= '0;
    end else begin
      fault.fault <= branchFaultE;
      // raw target, bit 0 still set when it faulted
      fault.adr   <= unalignedNext;
    end
  end

endmodule

//--- hw/instrMemory.sv
// instruction store: halfword array with a load port and an unaligned 32-bit read
`timescale 1ns/1ps

module instrMemory (
  input  logic                      clk,
  input  fetchPkg::imemLoadT        load,
  input  logic [fetchPkg::XLEN-1:0] pc,
  output logic [31:0]               instr
);

  import fetchPkg::*;

  // one entry per 16-bit parcel
  logic [15:0] mem [0:IMEM_HALFWORDS-1];

  // halfword at the pc
  logic [IMEM_AW-1:0] loIdx;
  // halfword after it, wraps at the top of the store
  logic [IMEM_AW-1:0] hiIdx;

  //////////////////////////////////////////////////////////////////////
  // load port
  //////////////////////////////////////////////////////////////////////

  // written by the testbench, contents survive reset
  always_ff @(posedge clk) begin
    if (load.we) begin
      mem[load.addr] <= load.data;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read port
  //////////////////////////////////////////////////////////////////////

  // pc bit 0 is always clear, bits above the store are ignored
  assign loIdx = pc[IMEM_AW:1];

  // modulo IMEM_HALFWORDS through the index width
  assign hiIdx = loIdx + 1'b1;

  // the second halfword forms the upper bits
  // a 32-bit instruction may straddle a word boundary
  // for a compressed instruction the upper half is just the next parcel
  assign instr = {mem[hiIdx], mem[loIdx]};

endmodule

//--- hw/pcDatapath.sv
// pc datapath: branch target adder, next-pc mux, pc register and 2-or-4 incrementer
`timescale 1ns/1ps

module pcDatapath (
  input  logic                       clk,
  input  logic                       reset,
  input  fetchPkg::pcSrcT            pcSel,
  input  logic                       pcEn,
  input  fetchPkg::branchResolveT    branch,
  input  logic [fetchPkg::XLEN-1:0]  privNextPc,
  input  logic [31:0]                instrF,
  output logic [fetchPkg::XLEN-1:0]  pcF,
  output logic [fetchPkg::XLEN-1:0]  pcPlusF,
  output logic [fetchPkg::XLEN-1:0]  unalignedNext
);

  import fetchPkg::*;

  // execute-stage branch or jump target
  logic [XLEN-1:0] pcTargetE;
  // next pc with bit 0 cleared
  logic [XLEN-1:0] pcNextF;
  // upper pc bits plus one, shared by +2 and +4
  logic [XLEN-3:0] pcUpperInc;
  // fetched instruction is 16 bits wide
  logic            compressedF;

  //////////////////////////////////////////////////////////////////////
  // next pc selection
  //////////////////////////////////////////////////////////////////////

  assign pcTargetE = branch.imm + branch.base;

  // three-way mux on the select from fetch control
  always_comb begin
    case (pcSel)
      pcPriv: begin
        unalignedNext = privNextPc;
      end
      pcBranch: begin
        unalignedNext = pcTargetE;
      end
      default: begin
        unalignedNext = pcPlusF;
      end
    endcase
  end

  // instructions sit on halfword boundaries, so bit 0 is dropped
  // the misaligned check still sees the raw value
  assign pcNextF = {unalignedNext[XLEN-1:1], 1'b0};

  //////////////////////////////////////////////////////////////////////
  // pc register
  //////////////////////////////////////////////////////////////////////

  // reset takes priority over the enable
  always_ff @(posedge clk) begin
    if (reset) begin
      pcF <= PC_START;
    end else if (pcEn) begin
      pcF <= pcNextF;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // sequential incrementer
  //////////////////////////////////////////////////////////////////////

  // low bits 11 mark a full 32-bit instruction
  assign compressedF = (instrF[1:0] != 2'b11);

  // one adder on the upper bits covers both step sizes
  assign pcUpperInc = pcF[XLEN-1:2] + 1'b1;

  always_comb begin
    if (compressedF) begin
      if (pcF[1]) begin
        // +2 from the upper halfword carries into the next word
        pcPlusF = {pcUpperInc, 2'b00};
      end else begin
        // +2 from the lower halfword stays in the word
        pcPlusF = {pcF[XLEN-1:2], 2'b10};
      end
    end else begin
      // +4 keeps the halfword offset
      pcPlusF = {pcUpperInc, pcF[1:0]};
    end
  end

endmodule

//--- hw/fetchControl.sv
// fetch control: resolves redirect priority and stall override into pc select and enable
`timescale 1ns/1ps

module fetchControl (
  input  logic            clk,
  input  logic            reset,
  input  logic            stallF,
  input  logic            branchTaken,
  input  logic            privRet,
  input  logic            privTrap,
  output fetchPkg::pcSrcT pcSel,
  output logic            pcEn
);

  import fetchPkg::*;

  // memory-stage return or trap wants the pc
  logic privRedirect;
  // any redirect, privileged or branch
  logic anyRedirect;
  // stall that is not overridden by a redirect
  logic stallHold;

  //////////////////////////////////////////////////////////////////////
  // redirect detection
  //////////////////////////////////////////////////////////////////////

  assign privRedirect = privRet | privTrap;
  assign anyRedirect  = privRedirect | branchTaken;

  // a redirect always wins over a fetch stall
  // so the redirected instruction is not lost
  assign stallHold = stallF & ~anyRedirect;

  //////////////////////////////////////////////////////////////////////
  // select and enable
  //////////////////////////////////////////////////////////////////////

  // privileged first, then branch, then sequential
  // during reset the datapath load of the reset vector is never blocked
  always_comb begin
    if (reset) begin
      pcSel = pcSeq;
    end else if (privRedirect) begin
      pcSel = pcPriv;
    end else if (branchTaken) begin
      pcSel = pcBranch;
    end else begin
      pcSel = pcSeq;
    end
  end

  // register enable drops only for a plain stall
  assign pcEn = reset | ~stallHold;

endmodule

//--- hw/fetchPkg.sv
// fetch stage package: widths, reset vector, memory depth and shared structs
package fetchPkg;

  //////////////////////////////////////////////////////////////////////
  // widths and constants
  //////////////////////////////////////////////////////////////////////

  // architectural register and pc width
  localparam int XLEN = 32;

  // reset vector
  localparam logic [XLEN-1:0] PC_START = 32'h0000_0080;

  // instruction store depth, counted in 16-bit halfwords
  localparam int IMEM_HALFWORDS = 128;
  // halfword address width
  localparam int IMEM_AW = 7;

  //////////////////////////////////////////////////////////////////////
  // shared types
  //////////////////////////////////////////////////////////////////////

  // next-pc source, listed from lowest to highest priority
  typedef enum logic [1:0] {
    pcSeq,
    pcBranch,
    pcPriv
  } pcSrcT;

  // execute-stage branch or jump outcome
  // target is imm + base
  typedef struct packed {
    logic            taken;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] base;
  } branchResolveT;

  // memory-stage privileged redirect (return or trap)
  typedef struct packed {
    logic            ret;
    logic            trap;
    logic [XLEN-1:0] nextPc;
  } privRedirectT;

  // what fetch hands to decode
  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [31:0]     instr;
    logic [XLEN-1:0] pcPlus;
  } fetchOutT;

  // instruction-misaligned fault, already in the memory stage
  typedef struct packed {
    logic            fault;
    logic [XLEN-1:0] adr;
  } misalignFaultT;

  // one halfword write into the instruction store
  typedef struct packed {
    logic               we;
    logic [IMEM_AW-1:0] addr;
    logic [15:0]        data;
  } imemLoadT;

endpackage
